// ==== issue_macros.svh ====
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// data path width
`define XLEN      32

// physical tag width, 32 physical registers
`define TAG_W     5

// reservation station slots
`define RS_SIZE   8

// op codes, 2 bits
`define OP_W      2
`define OP_ADD    2'd0
`define OP_SUB    2'd1
`define OP_XOR    2'd2
`define OP_MUL    2'd3

// one shift-add step per multiplier bit
`define MUL_STEPS `XLEN

`endif

// ==== issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    `include "issue_macros.svh"

    // data word on the register file and both CDB lanes
    typedef logic [`XLEN-1:0] word_t;

    // physical register tag
    typedef logic [`TAG_W-1:0] tag_t;

    // op code, see OP_* macros
    typedef logic [`OP_W-1:0] op_t;

    // step counter, holds 0 up to MUL_STEPS
    typedef logic [$clog2(`MUL_STEPS + 1)-1:0] step_t;

    // multiplier sequencing
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_t;

endpackage

`default_nettype wire

// ==== mul_step_counter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_macros.svh"

module mul_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step_en,
    output logic last_step
);

    issue_pkg::step_t count;

    always_ff @(posedge clk) begin
        if (rst || load) begin
            count <= '0;
        end else if (step_en) begin
            count <= count + 1'b1;
        end
    end

    // high during the final enabled step
    assign last_step = step_en && count == issue_pkg::step_t'(`MUL_STEPS - 1);

endmodule

`default_nettype wire

// ==== mul_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_datapath (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic             step_en,
    input  issue_pkg::tag_t  mul_dest,
    input  issue_pkg::word_t mul_a,
    input  issue_pkg::word_t mul_b,
    output issue_pkg::tag_t  cdb_mul_tag,
    output issue_pkg::word_t cdb_mul_data
);

    // multiplicand moves left, multiplier moves right
    issue_pkg::word_t mcand;
    issue_pkg::word_t mplier;
    issue_pkg::word_t product;

    always_ff @(posedge clk) begin
        if (rst) begin
            product     <= '0;
            cdb_mul_tag <= '0;
        end else if (load) begin
            product     <= '0;
            cdb_mul_tag <= mul_dest;
        end else if (step_en && mplier[0]) begin
            // low 32 bits only, carries out are dropped
            product <= product + mcand;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= mul_a;
            mplier <= mul_b;
        end else if (step_en) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign cdb_mul_data = product;

endmodule

`default_nettype wire

// ==== mul_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_control (
    input  logic             clk,
    input  logic             rst,
    input  logic             mul_issue,
    input  issue_pkg::tag_t  mul_dest,
    input  issue_pkg::word_t mul_a,
    input  issue_pkg::word_t mul_b,
    output logic             mul_ready,
    output logic             cdb_mul_valid,
    output issue_pkg::tag_t  cdb_mul_tag,
    output issue_pkg::word_t cdb_mul_data
);

    issue_pkg::mul_state_t state_q;
    issue_pkg::mul_state_t state_d;

    logic step_en;
    logic load;
    logic last_step;

    always_comb begin
        state_d = state_q;
        case (state_q)
            issue_pkg::MUL_IDLE: begin
                if (mul_issue) begin
                    state_d = issue_pkg::MUL_RUN;
                end
            end
            issue_pkg::MUL_RUN: begin
                if (last_step) begin
                    state_d = issue_pkg::MUL_DONE;
                end
            end
            // single broadcast cycle
            issue_pkg::MUL_DONE: state_d = issue_pkg::MUL_IDLE;
            default:             state_d = issue_pkg::MUL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= issue_pkg::MUL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // operands are latched at the issue edge
    assign load          = mul_issue && state_q == issue_pkg::MUL_IDLE;
    assign step_en       = state_q == issue_pkg::MUL_RUN;
    assign cdb_mul_valid = state_q == issue_pkg::MUL_DONE;
    assign mul_ready     = state_q == issue_pkg::MUL_IDLE;

    mul_step_counter u_counter (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step_en   (step_en),
        .last_step (last_step)
    );

    mul_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .step_en      (step_en),
        .mul_dest     (mul_dest),
        .mul_a        (mul_a),
        .mul_b        (mul_b),
        .cdb_mul_tag  (cdb_mul_tag),
        .cdb_mul_data (cdb_mul_data)
    );

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_macros.svh"

module alu_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             alu_issue,
    input  issue_pkg::op_t   alu_op,
    input  issue_pkg::tag_t  alu_dest,
    input  issue_pkg::word_t alu_a,
    input  issue_pkg::word_t alu_b,
    output logic             cdb_alu_valid,
    output issue_pkg::tag_t  cdb_alu_tag,
    output issue_pkg::word_t cdb_alu_data
);

    issue_pkg::word_t result;

    always_comb begin
        case (alu_op)
            `OP_ADD: result = alu_a + alu_b;
            `OP_SUB: result = alu_a - alu_b;
            `OP_XOR: result = alu_a ^ alu_b;
            // mul never reaches this unit
            default: result = '0;
        endcase
    end

    // one broadcast cycle per issue
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_alu_valid <= 1'b0;
        end else begin
            cdb_alu_valid <= alu_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            cdb_alu_tag  <= alu_dest;
            cdb_alu_data <= result;
        end
    end

endmodule

`default_nettype wire

// ==== phys_reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_macros.svh"

module phys_reg_file (
    input  logic             clk,
    input  logic             rst,
    // dispatch
    input  logic             disp_valid,
    input  issue_pkg::tag_t  disp_dest,
    input  issue_pkg::tag_t  disp_src1,
    input  issue_pkg::tag_t  disp_src2,
    output logic             src1_ready,
    output logic             src2_ready,
    // operand reads
    input  issue_pkg::tag_t  alu_src1,
    input  issue_pkg::tag_t  alu_src2,
    input  issue_pkg::tag_t  mul_src1,
    input  issue_pkg::tag_t  mul_src2,
    output issue_pkg::word_t alu_a,
    output issue_pkg::word_t alu_b,
    output issue_pkg::word_t mul_a,
    output issue_pkg::word_t mul_b,
    // write lanes
    input  logic             cdb_alu_valid,
    input  issue_pkg::tag_t  cdb_alu_tag,
    input  issue_pkg::word_t cdb_alu_data,
    input  logic             cdb_mul_valid,
    input  issue_pkg::tag_t  cdb_mul_tag,
    input  issue_pkg::word_t cdb_mul_data,
    input  logic             load_valid,
    input  issue_pkg::tag_t  load_tag,
    input  issue_pkg::word_t load_data
);

    localparam int NREGS = 1 << `TAG_W;

    issue_pkg::word_t regs [NREGS];
    logic [NREGS-1:0] ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            // all values zero and available
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            // clear first so a lane write to the same tag wins
            if (disp_valid) begin
                ready[disp_dest] <= 1'b0;
            end
            if (cdb_alu_valid) begin
                regs[cdb_alu_tag]  <= cdb_alu_data;
                ready[cdb_alu_tag] <= 1'b1;
            end
            if (cdb_mul_valid) begin
                regs[cdb_mul_tag]  <= cdb_mul_data;
                ready[cdb_mul_tag] <= 1'b1;
            end
            if (load_valid) begin
                regs[load_tag]  <= load_data;
                ready[load_tag] <= 1'b1;
            end
        end
    end

    // readiness at dispatch, lane bypass is in the station
    assign src1_ready = ready[disp_src1];
    assign src2_ready = ready[disp_src2];

    // operands in the issue strobe cycle
    assign alu_a = regs[alu_src1];
    assign alu_b = regs[alu_src2];
    assign mul_a = regs[mul_src1];
    assign mul_b = regs[mul_src2];

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_macros.svh"

module reservation_station (
    input  logic            clk,
    input  logic            rst,
    // dispatch
    input  logic            disp_valid,
    input  issue_pkg::op_t  disp_op,
    input  issue_pkg::tag_t disp_dest,
    input  issue_pkg::tag_t disp_src1,
    input  issue_pkg::tag_t disp_src2,
    input  logic            src1_ready,
    input  logic            src2_ready,
    // wakeup lanes
    input  logic            cdb_alu_valid,
    input  issue_pkg::tag_t cdb_alu_tag,
    input  logic            cdb_mul_valid,
    input  issue_pkg::tag_t cdb_mul_tag,
    input  logic            load_valid,
    input  issue_pkg::tag_t load_tag,
    input  logic            mul_ready,
    // alu issue
    output logic            alu_issue,
    output issue_pkg::op_t  alu_op,
    output issue_pkg::tag_t alu_dest,
    output issue_pkg::tag_t alu_src1,
    output issue_pkg::tag_t alu_src2,
    // mul issue
    output logic            mul_issue,
    output issue_pkg::tag_t mul_dest,
    output issue_pkg::tag_t mul_src1,
    output issue_pkg::tag_t mul_src2,
    output logic            table_full
);

    localparam int IDX_W = $clog2(`RS_SIZE);
    localparam int CNT_W = $clog2(`RS_SIZE + 1);

    // per-slot control
    logic            busy [`RS_SIZE];
    logic            met1 [`RS_SIZE];
    logic            met2 [`RS_SIZE];
    // per-slot payload
    issue_pkg::op_t  op_q   [`RS_SIZE];
    issue_pkg::tag_t dest_q [`RS_SIZE];
    issue_pkg::tag_t src1_q [`RS_SIZE];
    issue_pkg::tag_t src2_q [`RS_SIZE];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] mul_idx;
    logic             free_found;
    logic             alu_found;
    logic             mul_found;
    logic [CNT_W-1:0] count;
    logic             disp_take;

    // any of the three lanes broadcasting this tag now
    function automatic logic woken(input issue_pkg::tag_t t);
        woken = (cdb_alu_valid && cdb_alu_tag == t) ||
                (cdb_mul_valid && cdb_mul_tag == t) ||
                (load_valid && load_tag == t);
    endfunction

    // scan high to low so the lowest slot wins
    always_comb begin
        free_idx   = '0;
        alu_idx    = '0;
        mul_idx    = '0;
        free_found = 1'b0;
        alu_found  = 1'b0;
        mul_found  = 1'b0;
        count      = '0;
        for (int j = `RS_SIZE - 1; j >= 0; j--) begin
            count = count + CNT_W'(busy[j]);
            if (!busy[j]) begin
                free_idx   = IDX_W'(j);
                free_found = 1'b1;
            end
            if (busy[j] && met1[j] && met2[j]) begin
                if (op_q[j] != `OP_MUL) begin
                    alu_idx   = IDX_W'(j);
                    alu_found = 1'b1;
                end else if (mul_ready && !mul_issue) begin
                    // mul unit busy or about to be
                    mul_idx   = IDX_W'(j);
                    mul_found = 1'b1;
                end
            end
        end
    end

    // drop a dispatch when no slot is free
    assign disp_take = disp_valid && free_found;

    // full now, or full after this dispatch
    assign table_full = (count == CNT_W'(`RS_SIZE)) ||
                        (disp_valid && count == CNT_W'(`RS_SIZE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < `RS_SIZE; j++) begin
                busy[j] <= 1'b0;
                met1[j] <= 1'b0;
                met2[j] <= 1'b0;
            end
        end else begin
            // wakeup on occupied slots
            for (int j = 0; j < `RS_SIZE; j++) begin
                if (busy[j] && woken(src1_q[j])) begin
                    met1[j] <= 1'b1;
                end
                if (busy[j] && woken(src2_q[j])) begin
                    met2[j] <= 1'b1;
                end
            end
            // free the issued slots
            if (alu_found) begin
                busy[alu_idx] <= 1'b0;
            end
            if (mul_found) begin
                busy[mul_idx] <= 1'b0;
            end
            // new entry, same-cycle wakeup counts as met
            if (disp_take) begin
                busy[free_idx] <= 1'b1;
                met1[free_idx] <= src1_ready || woken(disp_src1);
                met2[free_idx] <= src2_ready || woken(disp_src2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_take) begin
            op_q[free_idx]   <= disp_op;
            dest_q[free_idx] <= disp_dest;
            src1_q[free_idx] <= disp_src1;
            src2_q[free_idx] <= disp_src2;
        end
    end

    // issue strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_issue <= 1'b0;
            mul_issue <= 1'b0;
        end else begin
            alu_issue <= alu_found;
            mul_issue <= mul_found;
        end
    end

    // issue payload, only meaningful with its strobe
    always_ff @(posedge clk) begin
        alu_op   <= op_q[alu_idx];
        alu_dest <= dest_q[alu_idx];
        alu_src1 <= src1_q[alu_idx];
        alu_src2 <= src2_q[alu_idx];
        mul_dest <= dest_q[mul_idx];
        mul_src1 <= src1_q[mul_idx];
        mul_src2 <= src2_q[mul_idx];
    end

endmodule

`default_nettype wire

// ==== issue_slice_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_slice_top (
    input  logic             clk,
    input  logic             rst,
    // dispatch
    input  logic             disp_valid,
    input  issue_pkg::op_t   disp_op,
    input  issue_pkg::tag_t  disp_dest,
    input  issue_pkg::tag_t  disp_src1,
    input  issue_pkg::tag_t  disp_src2,
    // external load lane
    input  logic             load_valid,
    input  issue_pkg::tag_t  load_tag,
    input  issue_pkg::word_t load_data,
    output logic             table_full,
    // result lanes
    output logic             cdb_alu_valid,
    output issue_pkg::tag_t  cdb_alu_tag,
    output issue_pkg::word_t cdb_alu_data,
    output logic             cdb_mul_valid,
    output issue_pkg::tag_t  cdb_mul_tag,
    output issue_pkg::word_t cdb_mul_data
);

    logic             src1_ready;
    logic             src2_ready;
    logic             mul_ready;
    logic             alu_issue;
    issue_pkg::op_t   alu_op;
    issue_pkg::tag_t  alu_dest;
    issue_pkg::tag_t  alu_src1;
    issue_pkg::tag_t  alu_src2;
    logic             mul_issue;
    issue_pkg::tag_t  mul_dest;
    issue_pkg::tag_t  mul_src1;
    issue_pkg::tag_t  mul_src2;
    issue_pkg::word_t alu_a;
    issue_pkg::word_t alu_b;
    issue_pkg::word_t mul_a;
    issue_pkg::word_t mul_b;

    reservation_station u_rs (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_dest     (disp_dest),
        .disp_src1     (disp_src1),
        .disp_src2     (disp_src2),
        .src1_ready    (src1_ready),
        .src2_ready    (src2_ready),
        .cdb_alu_valid (cdb_alu_valid),
        .cdb_alu_tag   (cdb_alu_tag),
        .cdb_mul_valid (cdb_mul_valid),
        .cdb_mul_tag   (cdb_mul_tag),
        .load_valid    (load_valid),
        .load_tag      (load_tag),
        .mul_ready     (mul_ready),
        .alu_issue     (alu_issue),
        .alu_op        (alu_op),
        .alu_dest      (alu_dest),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .mul_issue     (mul_issue),
        .mul_dest      (mul_dest),
        .mul_src1      (mul_src1),
        .mul_src2      (mul_src2),
        .table_full    (table_full)
    );

    phys_reg_file u_prf (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_dest     (disp_dest),
        .disp_src1     (disp_src1),
        .disp_src2     (disp_src2),
        .src1_ready    (src1_ready),
        .src2_ready    (src2_ready),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .mul_src1      (mul_src1),
        .mul_src2      (mul_src2),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .cdb_alu_valid (cdb_alu_valid),
        .cdb_alu_tag   (cdb_alu_tag),
        .cdb_alu_data  (cdb_alu_data),
        .cdb_mul_valid (cdb_mul_valid),
        .cdb_mul_tag   (cdb_mul_tag),
        .cdb_mul_data  (cdb_mul_data),
        .load_valid    (load_valid),
        .load_tag      (load_tag),
        .load_data     (load_data)
    );

    alu_unit u_alu (
        .clk           (clk),
        .rst           (rst),
        .alu_issue     (alu_issue),
        .alu_op        (alu_op),
        .alu_dest      (alu_dest),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .cdb_alu_valid (cdb_alu_valid),
        .cdb_alu_tag   (cdb_alu_tag),
        .cdb_alu_data  (cdb_alu_data)
    );

    mul_control u_mul (
        .clk           (clk),
        .rst           (rst),
        .mul_issue     (mul_issue),
        .mul_dest      (mul_dest),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .mul_ready     (mul_ready),
        .cdb_mul_valid (cdb_mul_valid),
        .cdb_mul_tag   (cdb_mul_tag),
        .cdb_mul_data  (cdb_mul_data)
    );

endmodule

`default_nettype wire

// ==== tb_issue_slice.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_macros.svh"

module tb_issue_slice;

    localparam int NTAGS = 1 << `TAG_W;

    // row kinds
    localparam logic [1:0] ROW_LOAD  = 2'd0;
    localparam logic [1:0] ROW_DISP  = 2'd1;
    localparam logic [1:0] ROW_DRAIN = 2'd2;
    // table_full not checked for this row
    localparam logic [1:0] FULL_ANY  = 2'd2;

    // lat holds the alu lane delay from the drive edge or 0 when untimed
    typedef struct packed {
        logic [1:0]       kind;
        issue_pkg::op_t   op;
        issue_pkg::tag_t  dest;
        issue_pkg::tag_t  src1;
        issue_pkg::tag_t  src2;
        issue_pkg::word_t data;
        logic [3:0]       lat;
        logic [1:0]       full;
    } row_t;

    logic             clk;
    logic             rst;
    logic             disp_valid;
    issue_pkg::op_t   disp_op;
    issue_pkg::tag_t  disp_dest;
    issue_pkg::tag_t  disp_src1;
    issue_pkg::tag_t  disp_src2;
    logic             load_valid;
    issue_pkg::tag_t  load_tag;
    issue_pkg::word_t load_data;
    logic             table_full;
    logic             cdb_alu_valid;
    issue_pkg::tag_t  cdb_alu_tag;
    issue_pkg::word_t cdb_alu_data;
    logic             cdb_mul_valid;
    issue_pkg::tag_t  cdb_mul_tag;
    issue_pkg::word_t cdb_mul_data;

    row_t             rows [$];
    // reference model with one entry per tag
    issue_pkg::word_t exp_val    [NTAGS];
    logic             dispatched [NTAGS];
    logic             seen       [NTAGS];
    logic             is_mul     [NTAGS];
    issue_pkg::tag_t  prod_a     [NTAGS];
    issue_pkg::tag_t  prod_b     [NTAGS];
    int               outstanding;
    int               cycle = 0;
    bit               built = 1'b0;
    issue_pkg::word_t rng;
    // pending timed alu results
    int               lat_cyc [$];
    issue_pkg::tag_t  lat_tag [$];

    issue_slice_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_dest     (disp_dest),
        .disp_src1     (disp_src1),
        .disp_src2     (disp_src2),
        .load_valid    (load_valid),
        .load_tag      (load_tag),
        .load_data     (load_data),
        .table_full    (table_full),
        .cdb_alu_valid (cdb_alu_valid),
        .cdb_alu_tag   (cdb_alu_tag),
        .cdb_alu_data  (cdb_alu_data),
        .cdb_mul_valid (cdb_mul_valid),
        .cdb_mul_tag   (cdb_mul_tag),
        .cdb_mul_data  (cdb_mul_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic issue_pkg::word_t xorshift(input issue_pkg::word_t s);
        issue_pkg::word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        xorshift = x;
    endfunction

    // op rules with mul keeping the low word
    function automatic issue_pkg::word_t op_result(input issue_pkg::op_t op,
                                                   input issue_pkg::word_t a,
                                                   input issue_pkg::word_t b);
        case (op)
            `OP_ADD: op_result = a + b;
            `OP_SUB: op_result = a - b;
            `OP_XOR: op_result = a ^ b;
            default: op_result = a * b;
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input issue_pkg::word_t got,
                              input issue_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input issue_pkg::tag_t got,
                             input issue_pkg::tag_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // one result seen on a cdb lane
    task automatic note_broadcast(input string lane, input logic mul_lane,
                                  input issue_pkg::tag_t t, input issue_pkg::word_t d);
        if (!dispatched[t]) begin
            stop_run($sformatf("%s broadcast tag %0d, which no dispatch produces", lane, t));
        end else if (seen[t]) begin
            stop_run($sformatf("%s broadcast tag %0d a second time", lane, t));
        end else if (is_mul[t] != mul_lane) begin
            stop_run($sformatf("tag %0d came out on the wrong lane (%s)", t, lane));
        end else if ((dispatched[prod_a[t]] && !seen[prod_a[t]]) ||
                     (dispatched[prod_b[t]] && !seen[prod_b[t]])) begin
            stop_run($sformatf("tag %0d was broadcast before its producer", t));
        end else begin
            check_word({lane, "_data"}, d, exp_val[t]);
            seen[t]     = 1'b1;
            outstanding = outstanding - 1;
        end
    endtask

    task automatic load_row(input issue_pkg::tag_t t, input issue_pkg::word_t d);
        row_t r;
        r      = '0;
        r.kind = ROW_LOAD;
        r.dest = t;
        r.data = d;
        r.full = FULL_ANY;
        rows.push_back(r);
    endtask

    task automatic op_row(input issue_pkg::op_t op, input issue_pkg::tag_t dest,
                          input issue_pkg::tag_t a, input issue_pkg::tag_t b,
                          input int lat, input logic [1:0] full);
        row_t r;
        r      = '0;
        r.kind = ROW_DISP;
        r.op   = op;
        r.dest = dest;
        r.src1 = a;
        r.src2 = b;
        r.lat  = 4'(lat);
        r.full = full;
        rows.push_back(r);
    endtask

    task automatic drain_row();
        row_t r;
        r      = '0;
        r.kind = ROW_DRAIN;
        r.full = FULL_ANY;
        rows.push_back(r);
    endtask

    task automatic build_table();
        rng = 32'd71;
        // operands and edge values for the multiplier
        rng = xorshift(rng);
        load_row(1, rng);
        rng = xorshift(rng);
        load_row(2, rng);
        load_row(3, 32'h0000_0000);
        load_row(4, 32'h0000_0001);
        load_row(5, 32'hffff_ffff);
        rng = xorshift(rng);
        load_row(6, rng);
        // lone alu ops take 3 cycles each
        op_row(`OP_ADD, 10, 1, 2, 3, FULL_ANY);
        op_row(`OP_SUB, 11, 1, 2, 3, FULL_ANY);
        op_row(`OP_XOR, 12, 2, 6, 3, FULL_ANY);
        // times random, zero, one, all-ones
        op_row(`OP_MUL, 13, 1, 2, 0, FULL_ANY);
        op_row(`OP_MUL, 14, 6, 3, 0, FULL_ANY);
        op_row(`OP_MUL, 15, 6, 4, 0, FULL_ANY);
        op_row(`OP_MUL, 16, 1, 5, 0, FULL_ANY);
        // mul -> alu -> mul -> alu chain
        op_row(`OP_ADD, 17, 16, 2, 0, FULL_ANY);
        op_row(`OP_MUL, 18, 17, 1, 0, FULL_ANY);
        op_row(`OP_XOR, 19, 18, 10, 0, FULL_ANY);
        // consumers right behind fresh loads
        rng = xorshift(rng);
        load_row(7, rng);
        op_row(`OP_SUB, 20, 7, 2, 0, FULL_ANY);
        rng = xorshift(rng);
        load_row(8, rng);
        op_row(`OP_MUL, 21, 8, 7, 0, FULL_ANY);
        drain_row();
        // one long producer with nine waiters on it
        op_row(`OP_MUL, 22, 1, 6, 0, 2'd0);
        for (int i = 0; i < 9; i++) begin
            // the eighth waiter takes the last free slot
            op_row(`OP_MUL, 5'(23 + i), 22, 5'((i % 8) + 1), 0, (i >= 7) ? 2'd1 : 2'd0);
        end
    endtask

    // outputs sampled half a cycle after the edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!rst) begin
            if (lat_cyc.size() > 0 && lat_cyc[0] == cycle) begin
                verify_flag("cdb_alu_valid", cdb_alu_valid, 1'b1);
                check_tag("cdb_alu_tag", cdb_alu_tag, lat_tag[0]);
                void'(lat_cyc.pop_front());
                void'(lat_tag.pop_front());
            end
            if (cdb_alu_valid) begin
                note_broadcast("cdb_alu", 1'b0, cdb_alu_tag, cdb_alu_data);
            end
            if (cdb_mul_valid) begin
                note_broadcast("cdb_mul", 1'b1, cdb_mul_tag, cdb_mul_data);
            end
        end
    end

    // budget grows with the table
    initial begin
        wait (built);
        repeat (rows.size() * (`MUL_STEPS + 10)) @(posedge clk);
        stop_run("timeout: results still missing when the cycle budget ran out");
    end

    initial begin
        row_t       r;
        logic [1:0] pend_full;
        rst         = 1'b1;
        disp_valid  = 1'b0;
        disp_op     = '0;
        disp_dest   = '0;
        disp_src1   = '0;
        disp_src2   = '0;
        load_valid  = 1'b0;
        load_tag    = '0;
        load_data   = '0;
        outstanding = 0;
        // registers come out of reset as zero
        for (int t = 0; t < NTAGS; t++) begin
            exp_val[t]    = '0;
            dispatched[t] = 1'b0;
            seen[t]       = 1'b0;
            is_mul[t]     = 1'b0;
            prod_a[t]     = '0;
            prod_b[t]     = '0;
        end
        build_table();
        built = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        pend_full = FULL_ANY;
        foreach (rows[i]) begin
            r = rows[i];
            @(negedge clk);
            // flag as seen after the previous row's drive edge
            if (pend_full != FULL_ANY) begin
                verify_flag("table_full", table_full, pend_full[0]);
            end
            if (r.kind == ROW_DISP) begin
                while (table_full) begin
                    @(posedge clk);
                    disp_valid <= 1'b0;
                    load_valid <= 1'b0;
                    @(negedge clk);
                end
            end
            @(posedge clk);
            disp_valid <= (r.kind == ROW_DISP);
            load_valid <= (r.kind == ROW_LOAD);
            pend_full = r.full;
            case (r.kind)
                ROW_LOAD: begin
                    load_tag       <= r.dest;
                    load_data      <= r.data;
                    exp_val[r.dest] = r.data;
                end
                ROW_DISP: begin
                    disp_op    <= r.op;
                    disp_dest  <= r.dest;
                    disp_src1  <= r.src1;
                    disp_src2  <= r.src2;
                    // sources always precede their users in the table
                    exp_val[r.dest]    = op_result(r.op, exp_val[r.src1], exp_val[r.src2]);
                    dispatched[r.dest] = 1'b1;
                    is_mul[r.dest]     = (r.op == `OP_MUL);
                    prod_a[r.dest]     = r.src1;
                    prod_b[r.dest]     = r.src2;
                    outstanding        = outstanding + 1;
                    if (r.lat != 0) begin
                        // next negedge is cycle + 1
                        lat_cyc.push_back(cycle + 1 + int'(r.lat));
                        lat_tag.push_back(r.dest);
                    end
                end
                default: begin
                    wait (outstanding == 0);
                end
            endcase
        end
        @(negedge clk);
        if (pend_full != FULL_ANY) begin
            verify_flag("table_full", table_full, pend_full[0]);
        end
        @(posedge clk);
        disp_valid <= 1'b0;
        load_valid <= 1'b0;
        wait (outstanding == 0);
        // late duplicates would still show here
        repeat (`MUL_STEPS + 4) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
issue_pkg.sv
mul_step_counter.sv
mul_datapath.sv
mul_control.sv
alu_unit.sv
phys_reg_file.sv
reservation_station.sv
issue_slice_top.sv
tb_issue_slice.sv

// ==== Bender.yml ====
package:
  name: issue_slice

sources:
  - include_dirs:
      - .
    files:
      - issue_pkg.sv
      - mul_step_counter.sv
      - mul_datapath.sv
      - mul_control.sv
      - alu_unit.sv
      - phys_reg_file.sv
      - reservation_station.sv
      - issue_slice_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_issue_slice.sv
